// ==== ntm_input_trainer.f ====
hw/ntm_trainer_pkg.sv
hw/ntm_trainer_decode.sv
hw/ntm_gate_differentiation.sv
hw/ntm_weight_gradient.sv
hw/ntm_input_trainer.sv
verif/ntm_input_trainer_checker.sv
verif/tb_ntm_input_trainer.sv

// ==== verif/tb_ntm_input_trainer.sv ====
`timescale 1ns/1ps

module tb_ntm_input_trainer
  import ntm_trainer_pkg::*;
();

  //////////////////////////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////////////////////////

  logic                   CLK;
  logic                   RST;
  logic                   START;
  logic [INDEX_WIDTH-1:0] SIZE_L_IN;
  logic [INDEX_WIDTH-1:0] SIZE_X_IN;
  logic [DATA_WIDTH-1:0]  A_IN;
  logic [DATA_WIDTH-1:0]  I_IN;
  logic [DATA_WIDTH-1:0]  S_IN;
  logic [DATA_WIDTH-1:0]  X_IN;
  logic                   A_IN_ENABLE;
  logic                   I_IN_ENABLE;
  logic                   S_IN_ENABLE;
  logic                   X_IN_ENABLE;
  logic [DATA_WIDTH-1:0]  B_OUT;
  logic [DATA_WIDTH-1:0]  W_OUT;
  logic                   B_OUT_ENABLE;
  logic                   W_OUT_X_ENABLE;
  logic                   W_OUT_L_ENABLE;
  logic                   READY;

  // Stimulus and expected gradients of the current run
  logic [DATA_WIDTH-1:0] a_v   [MAX_LENGTH];
  logic [DATA_WIDTH-1:0] i_v   [MAX_LENGTH];
  logic [DATA_WIDTH-1:0] s_v   [MAX_LENGTH];
  logic [DATA_WIDTH-1:0] x_v   [MAX_LENGTH];
  logic [DATA_WIDTH-1:0] exp_b [MAX_LENGTH];
  logic [DATA_WIDTH-1:0] exp_w [MAX_LENGTH*MAX_LENGTH];

  string test_name;
  int    cur_l;
  int    cur_x;
  int    b_count;
  int    w_count;
  int    ready_count;
  int    errors;
  int    timeouts;

  ntm_input_trainer u_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // di(l) = s*a*i*(1-i) and b(l) = di(l)
  // w(l,x) = di(l)*x(x) wrapping at DATA_WIDTH
  task automatic compute_model(input int l, input int x);
    logic [DATA_WIDTH-1:0] gate_slope;
    for (int r = 0; r < l; r++) begin
      gate_slope = 1 - i_v[r];
      exp_b[r]   = s_v[r] * a_v[r] * i_v[r] * gate_slope;
      for (int c = 0; c < x; c++) begin
        exp_w[r*x + c] = exp_b[r] * x_v[c];
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitor on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST) begin
      if (B_OUT_ENABLE) begin
        if (b_count >= cur_l) begin
          $display("Unexpected bias output beyond L in %s", test_name);
          errors++;
        end else if (B_OUT !== exp_b[b_count]) begin
          $display("ERR %s b[%0d] expected %h actual %h", test_name, b_count,
                   exp_b[b_count], B_OUT);
          errors++;
        end
        b_count++;
      end
      if (W_OUT_X_ENABLE) begin
        if (w_count >= cur_l * cur_x) begin
          $display("Unexpected weight output beyond L*X in %s", test_name);
          errors++;
        end else begin
          if (W_OUT !== exp_w[w_count]) begin
            $display("ERR %s w[%0d] expected %h actual %h", test_name, w_count,
                     exp_w[w_count], W_OUT);
            errors++;
          end
          // Row end on every X-th element
          if (W_OUT_L_ENABLE !== (w_count % cur_x == cur_x - 1)) begin
            $display("ERR %s row_end[%0d] expected %0b actual %0b", test_name, w_count,
                     (w_count % cur_x == cur_x - 1), W_OUT_L_ENABLE);
            errors++;
          end
        end
        w_count++;
      end
      if (READY) begin
        ready_count++;
        // READY only after the full gradient set
        if (b_count != cur_l || w_count != cur_l * cur_x) begin
          $display("ERR %s outputs_at_ready expected %0d actual %0d", test_name,
                   cur_l + cur_l * cur_x, b_count + w_count);
          errors++;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // One training step
  //////////////////////////////////////////////////////////////////////

  task automatic run_case(input string name, input int l, input int x,
                          input bit x_late, input bit busy_start);
    int  na;
    int  ni;
    int  ns;
    int  nx;
    int  guard;
    int  wait_cycles;
    bit  ais_done;
    test_name = name;
    cur_l     = l;
    cur_x     = x;
    for (int k = 0; k < MAX_LENGTH; k++) begin
      a_v[k] = $urandom;
      i_v[k] = $urandom;
      s_v[k] = $urandom;
      x_v[k] = $urandom;
    end
    compute_model(l, x);
    b_count     = 0;
    w_count     = 0;
    ready_count = 0;
    na          = 0;
    ni          = 0;
    ns          = 0;
    nx          = 0;
    guard       = 0;
    @(posedge CLK);
    START     <= 1'b1;
    SIZE_L_IN <= l;
    SIZE_X_IN <= x;
    // Shuffled streams with random idle gaps
    while ((na < l || ni < l || ns < l || nx < x) && guard < 1000) begin
      @(posedge CLK);
      ais_done    = (na == l) && (ni == l) && (ns == l);
      START       <= busy_start && (guard == 0);
      A_IN_ENABLE <= 1'b0;
      I_IN_ENABLE <= 1'b0;
      S_IN_ENABLE <= 1'b0;
      X_IN_ENABLE <= 1'b0;
      if (busy_start) begin
        SIZE_L_IN <= l % MAX_LENGTH + 1;
        SIZE_X_IN <= x % MAX_LENGTH + 1;
      end
      if (na < l && $urandom % 2) begin
        A_IN        <= a_v[na];
        A_IN_ENABLE <= 1'b1;
        na++;
      end
      if (ni < l && $urandom % 2) begin
        I_IN        <= i_v[ni];
        I_IN_ENABLE <= 1'b1;
        ni++;
      end
      if (ns < l && $urandom % 2) begin
        S_IN        <= s_v[ns];
        S_IN_ENABLE <= 1'b1;
        ns++;
      end
      // Late x only once a, i and s are all in
      if (nx < x && (!x_late || ais_done) && $urandom % 2) begin
        X_IN        <= x_v[nx];
        X_IN_ENABLE <= 1'b1;
        nx++;
      end
      guard++;
    end
    @(posedge CLK);
    START       <= 1'b0;
    A_IN_ENABLE <= 1'b0;
    I_IN_ENABLE <= 1'b0;
    S_IN_ENABLE <= 1'b0;
    X_IN_ENABLE <= 1'b0;
    wait_cycles = 0;
    while (ready_count == 0 && wait_cycles < 200) begin
      @(posedge CLK);
      wait_cycles++;
    end
    if (ready_count == 0) begin
      $display("Timeout in %s, READY never came", name);
      timeouts++;
    end else begin
      // Short quiet window to catch a second READY
      for (int k = 0; k < 4; k++) begin
        @(posedge CLK);
      end
      if (ready_count != 1) begin
        $display("ERR %s ready_pulses expected 1 actual %0d", name, ready_count);
        errors++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hdb1));
    RST         <= 1'b1;
    START       = 1'b0;
    SIZE_L_IN   = '0;
    SIZE_X_IN   = '0;
    A_IN        = '0;
    I_IN        = '0;
    S_IN        = '0;
    X_IN        = '0;
    A_IN_ENABLE = 1'b0;
    I_IN_ENABLE = 1'b0;
    S_IN_ENABLE = 1'b0;
    X_IN_ENABLE = 1'b0;
    test_name   = "reset";
    cur_l       = 0;
    cur_x       = 0;
    b_count     = 0;
    w_count     = 0;
    ready_count = 0;
    errors      = 0;
    timeouts    = 0;
    repeat (3) @(posedge CLK);
    RST <= 1'b0;
    repeat (2) @(posedge CLK);
    for (int t = 0; t < 8; t++) begin
      run_case("random", $urandom % 8 + 1, $urandom % 8 + 1, 1'b0, 1'b0);
    end
    run_case("edge_1x1", 1, 1, 1'b0, 1'b0);
    run_case("edge_8x8", 8, 8, 1'b0, 1'b0);
    for (int t = 0; t < 3; t++) begin
      run_case("x_late", $urandom % 8 + 1, $urandom % 8 + 1, 1'b1, 1'b0);
    end
    run_case("busy_start", 5, 3, 1'b0, 1'b1);
    run_case("busy_start_x_late", 2, 7, 1'b1, 1'b1);
    $display("Error counts: %0d check errors, %0d timeouts, %0d assertion failures",
             errors, timeouts, u_dut.u_checker.assert_failures);
    if (errors == 0 && timeouts == 0 && u_dut.u_checker.assert_failures == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== verif/ntm_input_trainer_checker.sv ====
`timescale 1ns/1ps

module ntm_input_trainer_checker (
  input logic CLK,
  input logic RST,
  input logic B_OUT_ENABLE,
  input logic W_OUT_X_ENABLE,
  input logic W_OUT_L_ENABLE,
  input logic READY
);

  // Number of failed assertions
  int assert_failures = 0;

  //////////////////////////////////////////////////////////////////////
  // Output strobe rules
  //////////////////////////////////////////////////////////////////////

  // Row end marker only rides on a weight element
  row_end_on_element: assert property (
    @(posedge CLK) disable iff (RST) W_OUT_L_ENABLE |-> W_OUT_X_ENABLE
  ) else begin
    $error("W_OUT_L_ENABLE high without W_OUT_X_ENABLE");
    assert_failures++;
  end

  // Bias phase and weight phase never overlap
  bias_weight_exclusive: assert property (
    @(posedge CLK) disable iff (RST) !(B_OUT_ENABLE && W_OUT_X_ENABLE)
  ) else begin
    $error("B_OUT_ENABLE and W_OUT_X_ENABLE high together");
    assert_failures++;
  end

  // Single-cycle READY
  ready_one_cycle: assert property (
    @(posedge CLK) disable iff (RST) READY |=> !READY
  ) else begin
    $error("READY high on two consecutive cycles");
    assert_failures++;
  end

  // All strobes quiet in reset
  quiet_in_reset: assert property (
    @(posedge CLK) RST |-> !(B_OUT_ENABLE || W_OUT_X_ENABLE || W_OUT_L_ENABLE || READY)
  ) else begin
    $error("Output strobe high during reset");
    assert_failures++;
  end

endmodule

bind ntm_input_trainer ntm_input_trainer_checker u_checker (
  .CLK            (CLK),
  .RST            (RST),
  .B_OUT_ENABLE   (B_OUT_ENABLE),
  .W_OUT_X_ENABLE (W_OUT_X_ENABLE),
  .W_OUT_L_ENABLE (W_OUT_L_ENABLE),
  .READY          (READY)
);

// ==== hw/ntm_input_trainer.sv ====
`timescale 1ns/1ps

module ntm_input_trainer
  import ntm_trainer_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   START,
  input  logic [INDEX_WIDTH-1:0] SIZE_L_IN,
  input  logic [INDEX_WIDTH-1:0] SIZE_X_IN,
  input  logic [DATA_WIDTH-1:0]  A_IN,
  input  logic [DATA_WIDTH-1:0]  I_IN,
  input  logic [DATA_WIDTH-1:0]  S_IN,
  input  logic [DATA_WIDTH-1:0]  X_IN,
  input  logic                   A_IN_ENABLE,
  input  logic                   I_IN_ENABLE,
  input  logic                   S_IN_ENABLE,
  input  logic                   X_IN_ENABLE,
  output logic [DATA_WIDTH-1:0]  B_OUT,
  output logic [DATA_WIDTH-1:0]  W_OUT,
  output logic                   B_OUT_ENABLE,
  output logic                   W_OUT_X_ENABLE,
  output logic                   W_OUT_L_ENABLE,
  output logic                   READY
);

  // Decode to execute, one operand set per cycle
  gate_operand_s operand;

  // Execute to result, two cycles behind operand
  gate_delta_s   delta;

  ntm_trainer_decode u_decode (
    .CLK         (CLK),
    .RST         (RST),
    .START       (START),
    .SIZE_L_IN   (SIZE_L_IN),
    .A_IN        (A_IN),
    .A_IN_ENABLE (A_IN_ENABLE),
    .I_IN        (I_IN),
    .I_IN_ENABLE (I_IN_ENABLE),
    .S_IN        (S_IN),
    .S_IN_ENABLE (S_IN_ENABLE),
    .operand     (operand)
  );

  ntm_gate_differentiation u_execute (
    .CLK     (CLK),
    .RST     (RST),
    .operand (operand),
    .delta   (delta)
  );

  ntm_weight_gradient u_result (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .SIZE_X_IN      (SIZE_X_IN),
    .X_IN           (X_IN),
    .X_IN_ENABLE    (X_IN_ENABLE),
    .delta          (delta),
    .B_OUT          (B_OUT),
    .W_OUT          (W_OUT),
    .B_OUT_ENABLE   (B_OUT_ENABLE),
    .W_OUT_X_ENABLE (W_OUT_X_ENABLE),
    .W_OUT_L_ENABLE (W_OUT_L_ENABLE),
    .READY          (READY)
  );

endmodule

// ==== hw/ntm_weight_gradient.sv ====
`timescale 1ns/1ps

module ntm_weight_gradient
  import ntm_trainer_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   START,
  input  logic [INDEX_WIDTH-1:0] SIZE_X_IN,
  input  logic [DATA_WIDTH-1:0]  X_IN,
  input  logic                   X_IN_ENABLE,
  input  gate_delta_s            delta,
  output logic [DATA_WIDTH-1:0]  B_OUT,
  output logic [DATA_WIDTH-1:0]  W_OUT,
  output logic                   B_OUT_ENABLE,
  output logic                   W_OUT_X_ENABLE,
  output logic                   W_OUT_L_ENABLE,
  output logic                   READY
);

  result_state_e state;

  // Sizes, X from START and L from the last delta
  logic [INDEX_WIDTH-1:0] size_x;
  logic [INDEX_WIDTH-1:0] size_l;
  logic [INDEX_WIDTH-1:0] x_ptr;
  logic [INDEX_WIDTH-1:0] x_ptr_nxt;
  logic                   take_x;
  logic                   last_seen;
  logic                   last_seen_nxt;
  logic                   collect_done;

  // Emission counters
  logic [INDEX_WIDTH-1:0] row;
  logic [INDEX_WIDTH-1:0] col;

  logic [DATA_WIDTH-1:0] x_buf  [MAX_LENGTH];
  logic [DATA_WIDTH-1:0] di_buf [MAX_LENGTH];

  //////////////////////////////////////////////////////////////////////
  // Collection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    take_x        = (state == RES_COLLECT) && X_IN_ENABLE && (x_ptr != size_x);
    x_ptr_nxt     = x_ptr + INDEX_WIDTH'(take_x);
    last_seen_nxt = last_seen || (delta.valid && delta.last);
    // both x and the last delta in hand after this edge
    collect_done  = (x_ptr_nxt == size_x) && last_seen_nxt;
  end

  // Deltas land by row index, order of arrival does not matter
  always_ff @(posedge CLK) begin
    if (take_x) begin
      x_buf[x_ptr[ADDR_WIDTH-1:0]] <= X_IN;
    end
    if (delta.valid) begin
      di_buf[delta.l[ADDR_WIDTH-1:0]] <= delta.di;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control FSM and outputs
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= RES_IDLE;
      size_x         <= '0;
      size_l         <= '0;
      x_ptr          <= '0;
      last_seen      <= 1'b0;
      row            <= '0;
      col            <= '0;
      B_OUT          <= '0;
      W_OUT          <= '0;
      B_OUT_ENABLE   <= 1'b0;
      W_OUT_X_ENABLE <= 1'b0;
      W_OUT_L_ENABLE <= 1'b0;
      READY          <= 1'b0;
    end else begin
      // Strobes are single-cycle by default
      B_OUT_ENABLE   <= 1'b0;
      W_OUT_X_ENABLE <= 1'b0;
      W_OUT_L_ENABLE <= 1'b0;
      READY          <= 1'b0;
      case (state)
        RES_IDLE: begin
          if (START) begin
            size_x    <= SIZE_X_IN;
            x_ptr     <= '0;
            last_seen <= 1'b0;
            state     <= RES_COLLECT;
          end
        end
        RES_COLLECT: begin
          x_ptr     <= x_ptr_nxt;
          last_seen <= last_seen_nxt;
          if (delta.valid && delta.last) begin
            size_l <= delta.l + INDEX_WIDTH'(1);
          end
          if (collect_done) begin
            row   <= '0;
            state <= RES_BIAS;
          end
        end
        RES_BIAS: begin
          // b(l) is di(l) for a single time step
          B_OUT        <= di_buf[row[ADDR_WIDTH-1:0]];
          B_OUT_ENABLE <= 1'b1;
          if (row == size_l - INDEX_WIDTH'(1)) begin
            row   <= '0;
            col   <= '0;
            state <= RES_WEIGHT;
          end else begin
            row <= row + INDEX_WIDTH'(1);
          end
        end
        RES_WEIGHT: begin
          // Row-major walk of w(l,x) = di(l) * x(x)
          W_OUT          <= DATA_WIDTH'(di_buf[row[ADDR_WIDTH-1:0]] *
                                        x_buf[col[ADDR_WIDTH-1:0]]);
          W_OUT_X_ENABLE <= 1'b1;
          if (col == size_x - INDEX_WIDTH'(1)) begin
            W_OUT_L_ENABLE <= 1'b1;
            col            <= '0;
            if (row == size_l - INDEX_WIDTH'(1)) begin
              state <= RES_DONE;
            end else begin
              row <= row + INDEX_WIDTH'(1);
            end
          end else begin
            col <= col + INDEX_WIDTH'(1);
          end
        end
        RES_DONE: begin
          READY <= 1'b1;
          state <= RES_IDLE;
        end
        default: begin
          state <= RES_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== hw/ntm_gate_differentiation.sv ====
`timescale 1ns/1ps

module ntm_gate_differentiation
  import ntm_trainer_pkg::*;
(
  input  logic          CLK,
  input  logic          RST,
  input  gate_operand_s operand,
  output gate_delta_s   delta
);

  // di = (s*a) * (i*(1-i)), split over two stages

  // Stage 1 partial products
  logic [DATA_WIDTH-1:0]  s1_sa;
  logic [DATA_WIDTH-1:0]  s1_ii;
  logic [INDEX_WIDTH-1:0] s1_l;
  logic                   s1_last;
  logic                   s1_valid;

  // Stage 2 result
  logic [DATA_WIDTH-1:0]  s2_di;
  logic [INDEX_WIDTH-1:0] s2_l;
  logic                   s2_last;
  logic                   s2_valid;

  //////////////////////////////////////////////////////////////////////
  // Valid pipe
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= operand.valid;
      s2_valid <= s1_valid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data pipe
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Stage 1, both products wrap at DATA_WIDTH
    s1_sa   <= DATA_WIDTH'(operand.s * operand.a);
    s1_ii   <= DATA_WIDTH'(operand.i * (ONE - operand.i));
    s1_l    <= operand.l;
    s1_last <= operand.last;
    // Stage 2
    s2_di   <= DATA_WIDTH'(s1_sa * s1_ii);
    s2_l    <= s1_l;
    s2_last <= s1_last;
  end

  assign delta = '{di: s2_di, l: s2_l, last: s2_last, valid: s2_valid};

endmodule

// ==== hw/ntm_trainer_decode.sv ====
`timescale 1ns/1ps

module ntm_trainer_decode
  import ntm_trainer_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   START,
  input  logic [INDEX_WIDTH-1:0] SIZE_L_IN,
  input  logic [DATA_WIDTH-1:0]  A_IN,
  input  logic                   A_IN_ENABLE,
  input  logic [DATA_WIDTH-1:0]  I_IN,
  input  logic                   I_IN_ENABLE,
  input  logic [DATA_WIDTH-1:0]  S_IN,
  input  logic                   S_IN_ENABLE,
  output gate_operand_s          operand
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  decode_state_e state;

  // Captured L and issue pointer
  logic [INDEX_WIDTH-1:0] size_l;
  logic [INDEX_WIDTH-1:0] rd_ptr;

  // Streams side by side, indexed by STREAM_*
  logic [NUM_STREAMS-1:0][DATA_WIDTH-1:0]  stream_data;
  logic [NUM_STREAMS-1:0]                  stream_en;
  logic [NUM_STREAMS-1:0]                  take;
  logic [NUM_STREAMS-1:0][INDEX_WIDTH-1:0] wr_ptr;
  logic [NUM_STREAMS-1:0][INDEX_WIDTH-1:0] wr_ptr_nxt;
  logic                                    load_done;

  // Element buffers
  logic [DATA_WIDTH-1:0] buffer [NUM_STREAMS][MAX_LENGTH];

  assign stream_data[STREAM_A] = A_IN;
  assign stream_data[STREAM_I] = I_IN;
  assign stream_data[STREAM_S] = S_IN;

  assign stream_en[STREAM_A] = A_IN_ENABLE;
  assign stream_en[STREAM_I] = I_IN_ENABLE;
  assign stream_en[STREAM_S] = S_IN_ENABLE;

  //////////////////////////////////////////////////////////////////////
  // Stream capture
  //////////////////////////////////////////////////////////////////////

  // Each stream advances on its own, extra elements are dropped
  always_comb begin
    for (int k = 0; k < NUM_STREAMS; k++) begin
      take[k]       = (state == DEC_LOAD) && stream_en[k] && (wr_ptr[k] != size_l);
      wr_ptr_nxt[k] = wr_ptr[k] + INDEX_WIDTH'(take[k]);
    end
    // Last of the three streams completes on this edge
    load_done = (wr_ptr_nxt[STREAM_A] == size_l) &&
                (wr_ptr_nxt[STREAM_I] == size_l) &&
                (wr_ptr_nxt[STREAM_S] == size_l);
  end

  always_ff @(posedge CLK) begin
    for (int k = 0; k < NUM_STREAMS; k++) begin
      if (take[k]) begin
        buffer[k][wr_ptr[k][ADDR_WIDTH-1:0]] <= stream_data[k];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= DEC_IDLE;
      size_l <= '0;
      rd_ptr <= '0;
      wr_ptr <= '0;
    end else begin
      case (state)
        DEC_IDLE: begin
          // START only counts here, busy START is dropped
          if (START) begin
            size_l <= SIZE_L_IN;
            wr_ptr <= '0;
            state  <= DEC_LOAD;
          end
        end
        DEC_LOAD: begin
          wr_ptr <= wr_ptr_nxt;
          if (load_done) begin
            rd_ptr <= '0;
            state  <= DEC_ISSUE;
          end
        end
        DEC_ISSUE: begin
          // One operand set per cycle, back to idle after row L-1
          rd_ptr <= rd_ptr + INDEX_WIDTH'(1);
          if (operand.last) begin
            state <= DEC_IDLE;
          end
        end
        default: begin
          state <= DEC_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operand output
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    operand.a     = buffer[STREAM_A][rd_ptr[ADDR_WIDTH-1:0]];
    operand.i     = buffer[STREAM_I][rd_ptr[ADDR_WIDTH-1:0]];
    operand.s     = buffer[STREAM_S][rd_ptr[ADDR_WIDTH-1:0]];
    operand.l     = rd_ptr;
    operand.last  = (rd_ptr == size_l - INDEX_WIDTH'(1));
    operand.valid = (state == DEC_ISSUE);
  end

endmodule

// ==== hw/ntm_trainer_pkg.sv ====
package ntm_trainer_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Element width, all arithmetic wraps at this width
  localparam int DATA_WIDTH = 16;

  // Largest L or X
  localparam int MAX_LENGTH = 8;

  // Holds a size from 1 to MAX_LENGTH
  localparam int INDEX_WIDTH = 4;

  // Buffer address, one less bit than a size
  localparam int ADDR_WIDTH = $clog2(MAX_LENGTH);

  // Operand streams gathered by decode
  localparam int NUM_STREAMS = 3;
  localparam int STREAM_A    = 0;
  localparam int STREAM_I    = 1;
  localparam int STREAM_S    = 2;

  // Unit element for the (1 - i) term
  localparam logic [DATA_WIDTH-1:0] ONE = DATA_WIDTH'(1);

  //////////////////////////////////////////////////////////////////////
  // FSM states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_LOAD,
    DEC_ISSUE
  } decode_state_e;

  typedef enum logic [2:0] {
    RES_IDLE,
    RES_COLLECT,
    RES_BIAS,
    RES_WEIGHT,
    RES_DONE
  } result_state_e;

  //////////////////////////////////////////////////////////////////////
  // Pipeline payloads
  //////////////////////////////////////////////////////////////////////

  // One element of each stream for row l
  typedef struct packed {
    logic [DATA_WIDTH-1:0]  a;
    logic [DATA_WIDTH-1:0]  i;
    logic [DATA_WIDTH-1:0]  s;
    logic [INDEX_WIDTH-1:0] l;
    logic                   last;
    logic                   valid;
  } gate_operand_s;

  // Input-gate delta for row l
  typedef struct packed {
    logic [DATA_WIDTH-1:0]  di;
    logic [INDEX_WIDTH-1:0] l;
    logic                   last;
    logic                   valid;
  } gate_delta_s;

endpackage
